// ==== all.f ====
design/arb_cfg_pkg.sv
design/arb_word_pkg.sv
design/arb_push_if.sv
design/skid_buf.sv
design/rr_select.sv
design/out_fifo.sv
design/stream_arbiter.sv
sim/stream_arbiter_asserts.sv
sim/tb_stream_arbiter.sv

// ==== design/arb_cfg_pkg.sv ====
`default_nettype none

// sizing defaults for the stream arbiter
// the top level takes these as parameter defaults and passes them down
package arb_cfg_pkg;

  // number of upstream valid/stall channels
  // must fit in the source tag, see arb_word_pkg
  localparam int DEF_NUM_IN = 4;

  // payload bits per word, same on every channel and on the output
  localparam int DEF_DATA_W = 16;

  // entries in the output fifo
  // any depth works, pointers wrap at the depth and not at a power of two
  localparam int DEF_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// ==== design/arb_push_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// push path from the round-robin selector into the output fifo
interface arb_push_if #(
  parameter int DATA_W = arb_cfg_pkg::DEF_DATA_W
) ();
  import arb_word_pkg::*;

  logic              push;      // write strobe, a word is taken on every edge it is high
  logic [DATA_W-1:0] push_data; // payload of the picked channel
  src_id_t           push_src;  // index of the picked channel
  logic              full;      // fifo has no room, selector holds off

  // selector side
  modport sel (
    output push,
    output push_data,
    output push_src,
    input  full
  );

  // fifo side, never sees a push while full
  modport fifo (
    input  push,
    input  push_data,
    input  push_src,
    output full
  );

endinterface

`default_nettype wire

// ==== design/arb_word_pkg.sv ====
`default_nettype none

// format of the word leaving the arbiter
// each output word is the payload plus a tag naming the channel it came from
package arb_word_pkg;

  // tag width, 4 bits name up to 16 upstream channels
  localparam int SRC_W = 4;

  // index of the input channel a word entered on
  // set by the selector when it picks a channel, kept next to the payload
  // in the output fifo and driven out on src_ds
  typedef logic [SRC_W-1:0] src_id_t;

endpackage

`default_nettype wire

// ==== design/out_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

// show-ahead output fifo for tagged words
// head entry is on data_ds/src_ds whenever the fifo is not empty,
// a downstream transfer pops it
module out_fifo #(
  parameter int DATA_W     = arb_cfg_pkg::DEF_DATA_W,
  parameter int FIFO_DEPTH = arb_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst,
  // from the selector
  arb_push_if.fifo              push_port,
  // downstream port
  output logic                  valid_ds,
  output logic [DATA_W-1:0]     data_ds,
  output arb_word_pkg::src_id_t src_ds,
  input  logic                  stall_ds
);
  import arb_word_pkg::*;

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1; // pointer bits
  localparam int CW = $clog2(FIFO_DEPTH + 1);                    // count 0..FIFO_DEPTH

  logic [DATA_W-1:0] data_mem [FIFO_DEPTH]; // payload storage
  src_id_t           src_mem  [FIFO_DEPTH]; // tag storage, same slot as payload
  logic [AW-1:0]     rd_ptr;                // head slot
  logic [AW-1:0]     wr_ptr;                // next free slot
  logic [CW-1:0]     count;                 // words held
  logic              empty;
  logic              push;
  logic              pop;

  // circular increment, wraps at the depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty          = (count == '0);
  assign push_port.full = (count == CW'(FIFO_DEPTH));

  // selector only pushes while not full
  assign push = push_port.push;
  assign pop  = valid_ds & ~stall_ds; // downstream transfer

  // head is presented straight from storage
  assign valid_ds = ~empty;
  assign data_ds  = data_mem[rd_ptr];
  assign src_ds   = src_mem[rd_ptr];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // a push never lands on the head while it is held, since wr_ptr meets rd_ptr
  // only when empty or full
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= push_port.push_data;
      src_mem[wr_ptr]  <= push_port.push_src;
    end
  end

endmodule

`default_nettype wire

// ==== design/rr_select.sv ====
`timescale 1ns/10ps
`default_nettype none

// rotating-priority selector
// picks at most one valid channel per cycle and pushes it, tagged with its
// index, into the output fifo; every other valid channel is stalled
module rr_select #(
  parameter int NUM_IN = arb_cfg_pkg::DEF_NUM_IN,
  parameter int DATA_W = arb_cfg_pkg::DEF_DATA_W
) (
  input  logic                          clk,
  input  logic                          rst,
  // from the skid buffers
  input  logic [NUM_IN-1:0]             valid_sk,
  input  logic [NUM_IN-1:0][DATA_W-1:0] data_sk,
  output logic [NUM_IN-1:0]             stall_sk,
  // into the output fifo
  arb_push_if.sel                       push_port
);
  import arb_word_pkg::*;

  // pointer needs at least one bit even for a single channel
  localparam int PTR_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [PTR_W-1:0]  ptr;       // channel with highest priority this cycle
  logic [PTR_W-1:0]  ptr_nxt;
  logic [NUM_IN-1:0] grant;     // one-hot, the picked channel
  logic              picked;    // some channel won
  src_id_t           pick_src;  // index of the winner
  logic [DATA_W-1:0] pick_data; // payload of the winner

  // search from ptr upwards with wrap, first valid channel wins
  // nothing is picked while the fifo is full
  always_comb begin
    int idx;
    idx       = 0;
    grant     = '0;
    picked    = 1'b0;
    pick_src  = '0;
    pick_data = '0;
    for (int k = 0; k < NUM_IN; k++) begin
      idx = (int'(ptr) + k) % NUM_IN; // wrap past the top channel
      if (!picked && valid_sk[idx] && !push_port.full) begin
        grant[idx] = 1'b1;
        picked     = 1'b1;
        pick_src   = src_id_t'(idx);
        pick_data  = data_sk[idx];
      end
    end
  end

  // losers hold, and with full high every valid channel holds
  assign stall_sk = valid_sk & ~grant;

  // push goes out in the same cycle the channel is valid
  assign push_port.push      = picked;
  assign push_port.push_data = pick_data;
  assign push_port.push_src  = pick_src;

  // step by one after each push, not to winner+1
  assign ptr_nxt = (ptr == PTR_W'(NUM_IN - 1)) ? '0 : ptr + 1'b1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ptr <= '0;
    end else if (picked) begin
      ptr <= ptr_nxt;
    end
  end

  // with every channel valid and the fifo draining, the pointer always names
  // a valid channel, so the winners run 0, 1, .. NUM_IN-1 and repeat

endmodule

`default_nettype wire

// ==== design/skid_buf.sv ====
`timescale 1ns/10ps
`default_nettype none

// one-channel valid/stall skid buffer
// upstream sees the downstream stall one cycle late, so a word can be accepted
// in the cycle the stall first rises; that word is parked in the skid register
module skid_buf #(
  parameter int DATA_W = arb_cfg_pkg::DEF_DATA_W
) (
  input  logic              clk,
  input  logic              rst,
  // upstream side
  input  logic              valid_us,
  input  logic [DATA_W-1:0] data_us,
  output logic              stall_us,
  // downstream side, towards the selector
  output logic              valid_ds,
  output logic [DATA_W-1:0] data_ds,
  input  logic              stall_ds
);

  logic              stall_q;    // stall_ds delayed by one cycle
  logic              skid_vld;   // skid register holds a word
  logic [DATA_W-1:0] skid_data;  // parked word
  logic              skid_load;  // park the live word this cycle
  logic              skid_drain; // parked word leaves this cycle

  // skid entry wins over the live input
  assign valid_ds = skid_vld | valid_us;
  assign data_ds  = skid_vld ? skid_data : data_us;

  // registered stall, only raised towards a producer that is offering
  assign stall_us = stall_q & valid_us;

  // live word got through upstream (stall not seen yet) but is stalled downstream
  assign skid_load = valid_us & ~stall_q & stall_ds & ~skid_vld;

  // parked word is presented first, it goes as soon as downstream lets go
  assign skid_drain = skid_vld & ~stall_ds;

  // control state
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stall_q  <= 1'b0;
      skid_vld <= 1'b0;
    end else begin
      stall_q <= stall_ds;
      if (skid_load) begin
        skid_vld <= 1'b1;
      end else if (skid_drain) begin
        skid_vld <= 1'b0;
      end
    end
  end

  // payload only moves on a load, qualified by skid_vld on the way out
  always_ff @(posedge clk) begin
    if (skid_load) begin
      skid_data <= data_us;
    end
  end

  // a loaded skid always has stall_q set the next cycle, so upstream is held
  // while the parked word drains and no word is taken twice

endmodule

`default_nettype wire

// ==== design/stream_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

// many-to-one stream arbiter
// NUM_IN valid/stall channels, each through a skid buffer, a round-robin
// selector, then a show-ahead fifo to one tagged valid/stall output
module stream_arbiter #(
  parameter int NUM_IN     = arb_cfg_pkg::DEF_NUM_IN,
  parameter int DATA_W     = arb_cfg_pkg::DEF_DATA_W,
  parameter int FIFO_DEPTH = arb_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  logic                          clk,
  input  logic                          rst,
  // upstream channels, packed across NUM_IN
  input  logic [NUM_IN-1:0]             valid_us,
  input  logic [NUM_IN-1:0][DATA_W-1:0] data_us,
  output logic [NUM_IN-1:0]             stall_us,
  // downstream port
  output logic                          valid_ds,
  output logic [DATA_W-1:0]             data_ds,
  output arb_word_pkg::src_id_t         src_ds,
  input  logic                          stall_ds
);
  import arb_word_pkg::*;

  // every channel needs its own tag value
  if (NUM_IN > (1 << SRC_W)) begin : g_tag_range
    $error("stream_arbiter: NUM_IN does not fit in the source tag");
  end

  logic [NUM_IN-1:0]             valid_sk; // skid buffer outputs
  logic [NUM_IN-1:0][DATA_W-1:0] data_sk;
  logic [NUM_IN-1:0]             stall_sk; // per-channel stall from the selector

  // selector to fifo
  arb_push_if #(.DATA_W(DATA_W)) push0 ();

  // one skid buffer per channel, clk and rst fan out to all
  skid_buf #(
    .DATA_W(DATA_W)
  ) skid0 [NUM_IN-1:0] (
    .clk      (clk),
    .rst      (rst),
    .valid_us (valid_us),
    .data_us  (data_us),
    .stall_us (stall_us),
    .valid_ds (valid_sk),
    .data_ds  (data_sk),
    .stall_ds (stall_sk)
  );

  rr_select #(
    .NUM_IN (NUM_IN),
    .DATA_W (DATA_W)
  ) sel0 (
    .clk       (clk),
    .rst       (rst),
    .valid_sk  (valid_sk),
    .data_sk   (data_sk),
    .stall_sk  (stall_sk),
    .push_port (push0.sel)
  );

  out_fifo #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk       (clk),
    .rst       (rst),
    .push_port (push0.fifo),
    .valid_ds  (valid_ds),
    .data_ds   (data_ds),
    .src_ds    (src_ds),
    .stall_ds  (stall_ds)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stream arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stream_arbiter -f all.f -o Vtb_stream_arbiter

# keep running past assertion errors so the testbench prints its summary
status=0
./obj_dir/Vtb_stream_arbiter +verilator+error+limit+1000 > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation FAILED, see $LOG"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "All tests passed" "$LOG"; then
  echo "simulation did not complete, see $LOG"
  exit 1
fi
echo "simulation passed"

// ==== sim/stream_arbiter_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

// port protocol checks, bound into every stream_arbiter
module stream_arbiter_asserts #(
  parameter int NUM_IN = arb_cfg_pkg::DEF_NUM_IN,
  parameter int DATA_W = arb_cfg_pkg::DEF_DATA_W
) (
  input logic                  clk,
  input logic                  rst,
  input logic [NUM_IN-1:0]     valid_us,
  input logic [NUM_IN-1:0]     stall_us,
  input logic                  valid_ds,
  input logic [DATA_W-1:0]     data_ds,
  input arb_word_pkg::src_id_t src_ds,
  input logic                  stall_ds
);
  import arb_word_pkg::*;

  int   fail_cnt = 0; // count of failed assertions that the testbench reads at the end
  logic offered_q;    // some channel has offered a word since reset

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      offered_q <= 1'b0;
    end else if (|valid_us) begin
      offered_q <= 1'b1;
    end
  end

  // outputs stay quiet until the first word is offered
  quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !offered_q |-> !valid_ds && (stall_us == '0))
  else begin
    $error("valid_ds or stall_us went high before any word was offered");
    fail_cnt++;
  end

  // a stalled output word holds until it is taken
  hold_under_stall: assert property (@(posedge clk) disable iff (rst)
    valid_ds && stall_ds |=> valid_ds && $stable(data_ds) && $stable(src_ds))
  else begin
    $error("stalled output word changed or dropped, data_ds now %h src_ds now %h",
           data_ds, src_ds);
    fail_cnt++;
  end

  // stall only towards a producer that offers
  stall_needs_valid: assert property (@(posedge clk) disable iff (rst)
    (stall_us & ~valid_us) == '0)
  else begin
    $error("stall_us %h raised on a channel without valid_us %h", stall_us, valid_us);
    fail_cnt++;
  end

endmodule

bind stream_arbiter stream_arbiter_asserts #(
  .NUM_IN (NUM_IN),
  .DATA_W (DATA_W)
) asrt0 (
  .clk      (clk),
  .rst      (rst),
  .valid_us (valid_us),
  .stall_us (stall_us),
  .valid_ds (valid_ds),
  .data_ds  (data_ds),
  .src_ds   (src_ds),
  .stall_ds (stall_ds)
);

`default_nettype wire

// ==== sim/tb_stream_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_stream_arbiter;
  import arb_cfg_pkg::*;
  import arb_word_pkg::*;

  localparam int NUM_IN     = DEF_NUM_IN;
  localparam int DATA_W     = DEF_DATA_W;
  localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
  localparam int SEQ_W      = DATA_W - SRC_W; // sequence field below the channel field

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int QUIET_CYCLES = 4;   // idle gap after reset
  localparam int RAND_CYCLES  = 400;
  localparam int FAIR_WARMUP  = FIFO_DEPTH + 2 * NUM_IN; // flush leftovers of the random phase
  localparam int FAIR_CYCLES  = 64;
  localparam int BP_CYCLES    = 20;
  localparam int FLUSH_CYCLES = 2 * (FIFO_DEPTH + NUM_IN); // idle streak that ends the drain
  localparam int DRAIN_CYCLES = 100; // allowance for the drain
  localparam int TEST_CYCLES  = RESET_CYCLES + QUIET_CYCLES + RAND_CYCLES + FAIR_WARMUP
                              + FAIR_CYCLES + BP_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD * 4;

  localparam int OFFER_NONE = 0; // no new words, pending ones still held
  localparam int OFFER_RAND = 1; // idle producers start a word by coin flip
  localparam int OFFER_ALL  = 2; // every producer always offers

  localparam logic [15:0] SEED = 16'd9434;

  logic                          clk = 1'b0;
  logic                          rst;
  logic [NUM_IN-1:0]             valid_us;
  logic [NUM_IN-1:0][DATA_W-1:0] data_us;
  logic [NUM_IN-1:0]             stall_us;
  logic                          valid_ds;
  logic [DATA_W-1:0]             data_ds;
  src_id_t                       src_ds;
  logic                          stall_ds;

  logic [15:0]      lfsr;
  logic [SEQ_W-1:0] next_seq [NUM_IN]; // sequence of the word each producer offers next
  logic [SEQ_W-1:0] exp_seq  [NUM_IN]; // sequence expected next at the output
  int               sent_cnt [NUM_IN];
  int               rcv_cnt  [NUM_IN];
  int               err_cnt = 0;
  int               fair_checks = 0;
  int               fair_q [$];      // sources of the last NUM_IN output words
  logic             fair_on = 1'b0;
  logic             bp_on   = 1'b0;
  logic             bp_seen = 1'b0;  // a word sat at the output during back-pressure

  stream_arbiter #(
    .NUM_IN     (NUM_IN),
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .valid_us (valid_us),
    .data_us  (data_us),
    .stall_us (stall_us),
    .valid_ds (valid_ds),
    .data_ds  (data_ds),
    .src_ds   (src_ds),
    .stall_ds (stall_ds)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // 16 bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic next_bit();
    lfsr = lfsr_step(lfsr); // one step per bit taken
    return lfsr[0];
  endfunction

  // one clock: note the upstream transfers of this edge, then drive new inputs
  task automatic step(input int mode, input logic stall_val);
    logic [NUM_IN-1:0] took;
    @(posedge clk);
    took = valid_us & ~stall_us;
    #0.5;
    for (int c = 0; c < NUM_IN; c++) begin
      if (took[c]) begin
        sent_cnt[c]++;
        next_seq[c]++;
        valid_us[c] = 1'b0;
      end
      // a pending word is held until it transfers
      if (!valid_us[c] && (mode == OFFER_ALL || (mode == OFFER_RAND && next_bit()))) begin
        valid_us[c] = 1'b1;
        data_us[c]  = {SRC_W'(c), next_seq[c]}; // channel on top, sequence below
      end
    end
    stall_ds = stall_val;
  endtask

  // output scoreboard, fairness window, back-pressure hold
  always @(posedge clk) begin
    int               s;
    logic [NUM_IN-1:0] mask;
    if (!rst && valid_ds && !stall_ds) begin
      s = int'(src_ds);
      assert (src_ds == data_ds[DATA_W-1 -: SRC_W]) else begin
        $display("MISMATCH src_ds: got %h expected %h", src_ds, data_ds[DATA_W-1 -: SRC_W]);
        err_cnt++;
      end
      if (s >= NUM_IN) begin
        $display("output word tagged with channel %0d, which does not exist", s);
        err_cnt++;
      end else begin
        assert (data_ds[SEQ_W-1:0] == exp_seq[s]) else begin
          $display("MISMATCH data_ds channel %0d: got %h expected %h",
                   s, data_ds[SEQ_W-1:0], exp_seq[s]);
          err_cnt++;
        end
        exp_seq[s] = data_ds[SEQ_W-1:0] + 1'b1; // resync, one slip gives one error
        rcv_cnt[s]++;
        if (fair_on) begin
          fair_q.push_back(s);
          if (fair_q.size() > NUM_IN) begin
            void'(fair_q.pop_front());
          end
          if (fair_q.size() == NUM_IN) begin
            mask = '0;
            foreach (fair_q[i]) begin
              mask[fair_q[i]] = 1'b1;
            end
            fair_checks++;
            assert (mask == '1) else begin
              $display("MISMATCH src_ds window: got %h expected %h", mask, {NUM_IN{1'b1}});
              err_cnt++;
            end
          end
        end
      end
    end
    if (!fair_on) begin
      fair_q.delete();
    end
    if (bp_on) begin
      if (valid_ds) begin
        bp_seen = 1'b1;
      end else if (bp_seen) begin
        $display("valid_ds dropped while stall_ds held the output");
        err_cnt++;
      end
    end
  end

  // stop a run that hangs
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout after %0d ns, run did not finish", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int   idle;
    int   asrt_errs;
    logic stall_pick;
    rst      = 1'b1;
    valid_us = '0;
    data_us  = '0;
    stall_ds = 1'b0;
    lfsr     = SEED;
    for (int c = 0; c < NUM_IN; c++) begin
      next_seq[c] = '0;
      exp_seq[c]  = '0;
      sent_cnt[c] = 0;
      rcv_cnt[c]  = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    rst = 1'b0;

    repeat (QUIET_CYCLES) step(OFFER_NONE, 1'b0);

    // random offers and random output stalls
    repeat (RAND_CYCLES) begin
      stall_pick = next_bit() & next_bit(); // stalled one cycle in four
      step(OFFER_RAND, stall_pick);
    end

    // all channels busy, output free
    repeat (FAIR_WARMUP) step(OFFER_ALL, 1'b0);
    fair_on = 1'b1;
    repeat (FAIR_CYCLES) step(OFFER_ALL, 1'b0);
    fair_on = 1'b0;

    // all channels busy, output held
    bp_on = 1'b1;
    repeat (BP_CYCLES) step(OFFER_ALL, 1'b1);
    bp_on = 1'b0;

    // drain until nothing is pending upstream or at the output
    idle = 0;
    while (idle < FLUSH_CYCLES) begin
      step(OFFER_NONE, 1'b0);
      if (valid_us == '0 && !valid_ds) begin
        idle++;
      end else begin
        idle = 0;
      end
    end

    for (int c = 0; c < NUM_IN; c++) begin
      assert (rcv_cnt[c] == sent_cnt[c]) else begin
        $display("MISMATCH rcv_cnt[%0d]: got %h expected %h", c, rcv_cnt[c], sent_cnt[c]);
        err_cnt++;
      end
    end
    if (fair_checks == 0) begin
      $display("fairness phase produced no full window of output words");
      err_cnt++;
    end
    if (!bp_seen) begin
      $display("no output word was seen during the back-pressure phase");
      err_cnt++;
    end

    asrt_errs = dut0.asrt0.fail_cnt;
    $display("errors: scoreboard %0d, bound assertions %0d", err_cnt, asrt_errs);
    if (err_cnt == 0 && asrt_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
